/* design/cl_decode.sv */
`timescale 1ns/1ps

module cl_decode (
    input  rv32_decode_pkg::instruction_s instruction_i,
    output rv32_decode_pkg::decode_s      decode_o
);
    import rv32_decode_pkg::*;

    // Instruction produces a result for rd
    always_comb begin
        unique casez (instruction_i.op)
            rv32_lui_op, rv32_auipc_op, rv32_jal_op, rv32_jalr_op,
            rv32_load, rv32_op, rv32_op_imm, rv32_amo:
                decode_o.op_writes_rf = 1'b1;
            default:
                decode_o.op_writes_rf = 1'b0;
        endcase
    end

    // Any data memory access
    always_comb begin
        unique casez (instruction_i.op)
            rv32_load, rv32_store:
                decode_o.is_mem_op = 1'b1;
            default:
                decode_o.is_mem_op = 1'b0;
        endcase
    end

    // Access size comes from funct3[1:0]
    always_comb begin
        decode_o.is_byte_op = (instruction_i.funct3[1:0] == 2'b00) & decode_o.is_mem_op;
    end

    always_comb begin
        decode_o.is_hex_op = (instruction_i.funct3[1:0] == 2'b01) & decode_o.is_mem_op;
    end

    always_comb begin
        unique casez (instruction_i.op)
            rv32_load:
                decode_o.is_load_op = 1'b1;
            default:
                decode_o.is_load_op = 1'b0;
        endcase
    end

    // LBU and LHU
    always_comb begin
        decode_o.is_load_unsigned = instruction_i.funct3[2] & decode_o.is_load_op;
    end

    always_comb begin
        unique casez (instruction_i.op)
            rv32_store:
                decode_o.is_store_op = 1'b1;
            default:
                decode_o.is_store_op = 1'b0;
        endcase
    end

    // Conditional branches only
    always_comb begin
        unique casez (instruction_i.op)
            rv32_branch:
                decode_o.is_branch_op = 1'b1;
            default:
                decode_o.is_branch_op = 1'b0;
        endcase
    end

    always_comb begin
        unique casez (instruction_i.op)
            rv32_jal_op, rv32_jalr_op:
                decode_o.is_jump_op = 1'b1;
            default:
                decode_o.is_jump_op = 1'b0;
        endcase
    end

    // Source operand usage
    always_comb begin
        unique casez (instruction_i.op)
            rv32_jalr_op, rv32_branch, rv32_load, rv32_store,
            rv32_op, rv32_op_imm, rv32_amo:
                decode_o.op_reads_rf1 = 1'b1;
            default:
                decode_o.op_reads_rf1 = 1'b0;
        endcase
    end

    always_comb begin
        unique casez (instruction_i.op)
            rv32_branch, rv32_store, rv32_op, rv32_amo:
                decode_o.op_reads_rf2 = 1'b1;
            default:
                decode_o.op_reads_rf2 = 1'b0;
        endcase
    end

    always_comb begin
        decode_o.op_is_auipc = (instruction_i.op == rv32_auipc_op);
    end

    // MUL/DIV family
    always_comb begin
        decode_o.is_md_instr = (instruction_i.op == rv32_op)
                             & (instruction_i.funct7 == rv32_md_funct7);
    end

    always_comb begin
        decode_o.op_is_load_reservation = (instruction_i ==? rv32_lr_w);
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  logic                             instr_v_i,
    input  rv32_decode_pkg::instruction_s    instr_i,
    input  logic                             wb_en_i,
    input  rv32_decode_pkg::reg_addr_t       wb_addr_i,
    input  logic [rv32_decode_pkg::xlen-1:0] wb_data_i,
    output logic                             valid_o,
    output rv32_decode_pkg::decode_s         decode_o,
    output rv32_decode_pkg::reg_addr_t       rd_o,
    output logic [rv32_decode_pkg::xlen-1:0] imm_o,
    output logic [rv32_decode_pkg::xlen-1:0] rs1_data_o,
    output logic [rv32_decode_pkg::xlen-1:0] rs2_data_o
);
    import rv32_decode_pkg::*;

    logic            ir_v;
    instruction_s    ir_q;
    decode_s         dec;
    logic [xlen-1:0] imm;
    stage_out_s      out_d;
    stage_out_s      out_q;

    rf_read_if rf_rd ();

    // Instruction register
    pipe_reg #(
        .payload_t (instruction_s)
    ) ir_reg_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (instr_v_i),
        .data_i   (instr_i),
        .v_o      (ir_v),
        .data_o   (ir_q)
    );

    cl_decode decoder_i (
        .instruction_i (ir_q),
        .decode_o      (dec)
    );

    imm_gen imm_gen_i (
        .instruction_i (ir_q),
        .imm_o         (imm)
    );

    // Source indices straight from the latched instruction
    assign rf_rd.rs1_addr = ir_q.rs1;
    assign rf_rd.rs2_addr = ir_q.rs2;

    reg_file reg_file_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wb_en_i   (wb_en_i),
        .wb_addr_i (wb_addr_i),
        .wb_data_i (wb_data_i),
        .rd_port   (rf_rd)
    );

    always_comb begin
        out_d.decode   = dec;
        out_d.rd       = ir_q.rd;
        out_d.imm      = imm;
        out_d.rs1_data = rf_rd.rs1_data;
        out_d.rs2_data = rf_rd.rs2_data;
    end

    // Register toward execute
    pipe_reg #(
        .payload_t (stage_out_s)
    ) out_reg_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (ir_v),
        .data_i   (out_d),
        .v_o      (valid_o),
        .data_o   (out_q)
    );

    assign decode_o   = out_q.decode;
    assign rd_o       = out_q.rd;
    assign imm_o      = out_q.imm;
    assign rs1_data_o = out_q.rs1_data;
    assign rs2_data_o = out_q.rs2_data;

endmodule

/* design/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  rv32_decode_pkg::instruction_s     instruction_i,
    output logic [rv32_decode_pkg::xlen-1:0]  imm_o
);
    import rv32_decode_pkg::*;

    logic [31:0]     instr;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    assign instr = instruction_i;

    // Bit 31 is the sign for every format
    assign i_imm = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign s_imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{(xlen-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {{(xlen-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};

    // Format follows the opcode
    always_comb begin
        unique casez (instruction_i.op)
            rv32_jalr_op, rv32_load, rv32_op_imm, rv32_system:
                imm_o = i_imm;
            rv32_store:
                imm_o = s_imm;
            rv32_branch:
                imm_o = b_imm;
            rv32_lui_op, rv32_auipc_op:
                imm_o = u_imm;
            rv32_jal_op:
                imm_o = j_imm;
            // Register-register and AMO carry no immediate
            default:
                imm_o = '0;
        endcase
    end

endmodule

/* design/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     v_i,
    input  payload_t data_i,
    output logic     v_o,
    output payload_t data_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            v_o <= 1'b0;
        end else begin
            v_o <= v_i;
        end
    end

    // Payload holds through bubbles
    always_ff @(posedge clk_i) begin
        if (v_i) begin
            data_o <= data_i;
        end
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  logic                             wb_en_i,
    input  rv32_decode_pkg::reg_addr_t       wb_addr_i,
    input  logic [rv32_decode_pkg::xlen-1:0] wb_data_i,
    rf_read_if.provider                      rd_port
);
    import rv32_decode_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs_q [1:reg_count-1];
    logic            wb_active;

    assign wb_active = wb_en_i & (wb_addr_i != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < reg_count; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_active) begin
            regs_q[wb_addr_i] <= wb_data_i;
        end
    end

    // Zero for x0, then bypass of a write landing this cycle
    function automatic logic [xlen-1:0] read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_active && (addr == wb_addr_i)) begin
            return wb_data_i;
        end
        return regs_q[addr];
    endfunction

    always_comb begin
        rd_port.rs1_data = read_port(rd_port.rs1_addr);
        rd_port.rs2_data = read_port(rd_port.rs2_addr);
    end

endmodule

/* design/rf_read_if.sv */
`timescale 1ns/1ps

interface rf_read_if;
    import rv32_decode_pkg::*;

    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    // Decode side presents addresses
    modport reader (
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data
    );

    // Register file answers in the same cycle
    modport provider (
        input  rs1_addr,
        input  rs2_addr,
        output rs1_data,
        output rs2_data
    );

endinterface

/* design/rv32_decode_pkg.sv */
package rv32_decode_pkg;

    // Datapath and register file sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 2 ** reg_addr_w;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Standard RV32 field layout, op in the low bits
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] op;
    } instruction_s;

    typedef struct packed {
        logic op_writes_rf;
        logic is_mem_op;
        logic is_byte_op;
        logic is_hex_op;
        logic is_load_op;
        logic is_load_unsigned;
        logic is_store_op;
        logic is_branch_op;
        logic is_jump_op;
        logic op_reads_rf1;
        logic op_reads_rf2;
        logic op_is_auipc;
        logic is_md_instr;
        logic op_is_load_reservation;
    } decode_s;

    // Major opcodes
    localparam logic [6:0] rv32_lui_op   = 7'b0110111;
    localparam logic [6:0] rv32_auipc_op = 7'b0010111;
    localparam logic [6:0] rv32_jal_op   = 7'b1101111;
    localparam logic [6:0] rv32_jalr_op  = 7'b1100111;
    localparam logic [6:0] rv32_branch   = 7'b1100011;
    localparam logic [6:0] rv32_load     = 7'b0000011;
    localparam logic [6:0] rv32_store    = 7'b0100011;
    localparam logic [6:0] rv32_op_imm   = 7'b0010011;
    localparam logic [6:0] rv32_op       = 7'b0110011;
    localparam logic [6:0] rv32_amo      = 7'b0101111;
    localparam logic [6:0] rv32_system   = 7'b1110011;

    // M extension lives under OP with this funct7
    localparam logic [6:0] rv32_md_funct7 = 7'b0000001;

    // LR.W with aq/rl and rd/rs1 left as don't care
    localparam logic [31:0] rv32_lr_w = 32'b00010_??_00000_?????_010_?????_0101111;

    // Payload handed to execute
    typedef struct packed {
        decode_s         decode;
        reg_addr_t       rd;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
    } stage_out_s;

endpackage

/* verif/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker (
    input  logic                             clk_i,
    input  logic                             valid_i,
    input  rv32_decode_pkg::decode_s         decode_i,
    input  rv32_decode_pkg::reg_addr_t       rd_i,
    input  logic [rv32_decode_pkg::xlen-1:0] imm_i,
    input  logic [rv32_decode_pkg::xlen-1:0] rs1_data_i,
    input  logic [rv32_decode_pkg::xlen-1:0] rs2_data_i
);
    import rv32_decode_pkg::*;

    stage_out_s exp_q[$];
    int         errors = 0;
    int         seen   = 0;

    // Called by the testbench for every valid instruction it drives
    task automatic push_expect(input stage_out_s exp);
        exp_q.push_back(exp);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        stage_out_s exp;
        if (valid_i === 1'b1) begin
            seen++;
            if (exp_q.size() == 0) begin
                $display("valid_o with empty queue");
                errors++;
            end else begin
                exp = exp_q.pop_front();
                compare_field("decode_o", 32'(decode_i), 32'(exp.decode));
                compare_field("rd_o", 32'(rd_i), 32'(exp.rd));
                compare_field("imm_o", imm_i, exp.imm);
                compare_field("rs1_data_o", rs1_data_i, exp.rs1_data);
                compare_field("rs2_data_o", rs2_data_i, exp.rs2_data);
            end
        end
    end

endmodule

/* verif/decode_stage_props.sv */
`timescale 1ns/1ps

module decode_stage_props (
    input logic                             clk_i,
    input logic                             arst_n_i,
    input logic                             instr_v_i,
    input logic                             valid_i,
    input logic                             ir_v_i,
    input rv32_decode_pkg::reg_addr_t       rs1_addr_i,
    input logic [rv32_decode_pkg::xlen-1:0] rs1_data_i
);
    import rv32_decode_pkg::*;

    int fail_count = 0;

    a_reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !valid_i)
        else begin
            $error("valid_o high during reset");
            fail_count++;
        end

    // Fixed two edge latency in both directions
    a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_v_i |-> ##2 valid_i)
        else begin
            $error("valid_o missing two edges after instr_v_i");
            fail_count++;
        end

    a_no_extra: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !instr_v_i |-> ##2 !valid_i)
        else begin
            $error("valid_o without a matching instr_v_i");
            fail_count++;
        end

    a_x0_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ir_v_i && rs1_addr_i == '0) |-> rs1_data_i == '0)
        else begin
            $error("x0 read returned nonzero data");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_props props_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .instr_v_i  (instr_v_i),
    .valid_i    (valid_o),
    .ir_v_i     (ir_v),
    .rs1_addr_i (ir_q.rs1),
    .rs1_data_i (out_d.rs1_data)
);

/* verif/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;
    import rv32_decode_pkg::*;

    localparam int num_recs   = 24;
    localparam int wd_cycles  = num_recs * 4 + 50;

    typedef struct packed {
        instruction_s    instr;
        logic            wb_en;
        reg_addr_t       wb_addr;
        logic [xlen-1:0] wb_data;
        decode_s         dec;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
    } test_rec_s;

    logic            clk_i = 1'b0;
    logic            arst_n_i;
    logic            instr_v_i;
    instruction_s    instr_i;
    logic            wb_en_i;
    reg_addr_t       wb_addr_i;
    logic [xlen-1:0] wb_data_i;
    logic            valid_o;
    decode_s         decode_o;
    reg_addr_t       rd_o;
    logic [xlen-1:0] imm_o;
    logic [xlen-1:0] rs1_data_o;
    logic [xlen-1:0] rs2_data_o;

    test_rec_s       tbl[num_recs];
    int              n_add = 0;
    logic [31:0]     rng   = 32'haf2;
    logic            pend_en;
    reg_addr_t       pend_addr;
    logic [xlen-1:0] pend_data;

    always #50 clk_i = ~clk_i;

    decode_stage dut_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .instr_v_i  (instr_v_i),
        .instr_i    (instr_i),
        .wb_en_i    (wb_en_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .valid_o    (valid_o),
        .decode_o   (decode_o),
        .rd_o       (rd_o),
        .imm_o      (imm_o),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

    decode_checker chk_i (
        .clk_i      (clk_i),
        .valid_i    (valid_o),
        .decode_i   (decode_o),
        .rd_i       (rd_o),
        .imm_i      (imm_o),
        .rs1_data_i (rs1_data_o),
        .rs2_data_i (rs2_data_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Instruction encoders per format
    function automatic instruction_s r_type(input logic [6:0] f7, input reg_addr_t rs2,
        input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic instruction_s i_type(input logic [11:0] imm, input reg_addr_t rs1,
        input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instruction_s s_type(input logic [11:0] imm, input reg_addr_t rs2,
        input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32_store};
    endfunction

    function automatic instruction_s b_type(input logic [12:0] imm, input reg_addr_t rs2,
        input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32_branch};
    endfunction

    function automatic instruction_s u_type(input logic [19:0] imm, input reg_addr_t rd,
        input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instruction_s j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32_jal_op};
    endfunction

    task automatic add_rec(input instruction_s ins, input logic wb_en, input reg_addr_t wb_addr,
        input logic [31:0] wb_data, input logic [13:0] dec, input logic [31:0] imm,
        input logic [31:0] rs1, input logic [31:0] rs2);
        tbl[n_add] = '{ins, wb_en, wb_addr, wb_data, decode_s'(dec), imm, rs1, rs2};
        n_add++;
    endtask

    // Write-back of a record is held during its own decode cycle
    task automatic drive_cycle(input logic v, input instruction_s ins);
        @(negedge clk_i);
        instr_v_i = v;
        instr_i   = ins;
        wb_en_i   = pend_en;
        wb_addr_i = pend_en ? pend_addr : '0;
        wb_data_i = pend_en ? pend_data : '0;
        pend_en   = 1'b0;
    endtask

    task automatic build_table();
        // Flag bit order wr mem byte hex ld uns st br jmp rf1 rf2 auipc md lr
        add_rec(i_type(12'h7ff, 0, 0, 1, rv32_op_imm), 1, 1, 32'h11111111,
                14'b10000000010000, 32'h000007ff, 32'h0, 32'h0);
        add_rec(r_type(0, 2, 1, 0, 2, rv32_op), 1, 2, 32'h22222222,
                14'b10000000011000, 32'h0, 32'h11111111, 32'h22222222);
        add_rec(i_type(12'hfff, 2, 0, 3, rv32_op_imm), 1, 3, 32'h80000003,
                14'b10000000010000, 32'hffffffff, 32'h22222222, 32'h0);
        add_rec(r_type(0, 0, 0, 0, 0, rv32_op), 1, 0, 32'hdeadbeef,
                14'b10000000011000, 32'h0, 32'h0, 32'h0);
        add_rec(r_type(0, 3, 0, 0, 4, rv32_op), 0, 0, 32'h0,
                14'b10000000011000, 32'h0, 32'h0, 32'h80000003);
        add_rec(u_type(20'hfff00, 5, rv32_lui_op), 0, 0, 32'h0,
                14'b10000000000000, 32'hfff00000, 32'h0, 32'h0);
        add_rec(u_type(20'h00400, 6, rv32_auipc_op), 0, 0, 32'h0,
                14'b10000000000100, 32'h00400000, 32'h0, 32'h0);
        add_rec(j_type(21'h000100, 7), 0, 0, 32'h0,
                14'b10000000100000, 32'h00000100, 32'h0, 32'h0);
        add_rec(i_type(12'h010, 1, 0, 9, rv32_jalr_op), 0, 0, 32'h0,
                14'b10000000110000, 32'h00000010, 32'h11111111, 32'h0);
        add_rec(b_type(13'h1ff8, 2, 1, 0), 0, 0, 32'h0,
                14'b00000001011000, 32'hfffffff8, 32'h11111111, 32'h22222222);
        add_rec(i_type(12'h004, 2, 3'b000, 10, rv32_load), 0, 0, 32'h0,
                14'b11101000010000, 32'h00000004, 32'h22222222, 32'h0);
        add_rec(i_type(12'hffe, 3, 3'b001, 11, rv32_load), 0, 0, 32'h0,
                14'b11011000010000, 32'hfffffffe, 32'h80000003, 32'h0);
        add_rec(i_type(12'h000, 1, 3'b010, 12, rv32_load), 0, 0, 32'h0,
                14'b11001000010000, 32'h0, 32'h11111111, 32'h0);
        add_rec(i_type(12'h001, 0, 3'b100, 13, rv32_load), 0, 0, 32'h0,
                14'b11101100010000, 32'h00000001, 32'h0, 32'h11111111);
        add_rec(i_type(12'h002, 0, 3'b101, 14, rv32_load), 0, 0, 32'h0,
                14'b11011100010000, 32'h00000002, 32'h0, 32'h22222222);
        add_rec(s_type(12'hffc, 2, 1, 3'b010), 0, 0, 32'h0,
                14'b01000010011000, 32'hfffffffc, 32'h11111111, 32'h22222222);
        add_rec(s_type(12'h07f, 3, 0, 3'b000), 0, 0, 32'h0,
                14'b01100010011000, 32'h0000007f, 32'h0, 32'h80000003);
        add_rec(r_type(7'h01, 2, 1, 3'b000, 15, rv32_op), 0, 0, 32'h0,
                14'b10000000011010, 32'h0, 32'h11111111, 32'h22222222);
        add_rec(r_type(7'h01, 1, 3, 3'b100, 16, rv32_op), 0, 0, 32'h0,
                14'b10000000011010, 32'h0, 32'h80000003, 32'h11111111);
        add_rec(r_type(7'b0001000, 0, 2, 3'b010, 17, rv32_amo), 0, 0, 32'h0,
                14'b10000000011001, 32'h0, 32'h22222222, 32'h0);
        add_rec(r_type(7'h00, 3, 1, 3'b010, 18, rv32_amo), 0, 0, 32'h0,
                14'b10000000011000, 32'h0, 32'h11111111, 32'h80000003);
        add_rec(i_type(12'h000, 0, 0, 0, rv32_system), 0, 0, 32'h0,
                14'b00000000000000, 32'h0, 32'h0, 32'h0);
        add_rec(r_type(0, 2, 1, 0, 19, rv32_op), 1, 1, 32'h5a5a5a5a,
                14'b10000000011000, 32'h0, 32'h5a5a5a5a, 32'h22222222);
        add_rec(r_type(0, 0, 1, 0, 20, rv32_op), 0, 0, 32'h0,
                14'b10000000011000, 32'h0, 32'h5a5a5a5a, 32'h0);
    endtask

    // Watchdog sized from the table length
    initial begin
        repeat (wd_cycles) @(posedge clk_i);
        $display("timeout: the DUT did not deliver all outputs in time");
        $display("test failed");
        $finish;
    end

    initial begin
        stage_out_s exp;
        int         gaps;
        int         total_errors;
        arst_n_i  = 1'b0;
        instr_v_i = 1'b0;
        instr_i   = '0;
        wb_en_i   = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        pend_en   = 1'b0;
        pend_addr = '0;
        pend_data = '0;
        build_table();
        repeat (10) @(negedge clk_i);
        arst_n_i = 1'b1;

        for (int i = 0; i < num_recs; i++) begin
            rng = xorshift(rng);
            gaps = (rng[1:0] == 2'b00) ? int'(rng[2]) + 1 : 0;
            repeat (gaps) drive_cycle(1'b0, '0);
            drive_cycle(1'b1, tbl[i].instr);
            pend_en   = tbl[i].wb_en;
            pend_addr = tbl[i].wb_addr;
            pend_data = tbl[i].wb_data;
            exp.decode   = tbl[i].dec;
            exp.rd       = tbl[i].instr.rd;
            exp.imm      = tbl[i].imm;
            exp.rs1_data = tbl[i].rs1;
            exp.rs2_data = tbl[i].rs2;
            chk_i.push_expect(exp);
        end
        drive_cycle(1'b0, '0);

        while (chk_i.pending() != 0) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        if (chk_i.seen != num_recs) begin
            $display("output count %0d does not match %0d instructions", chk_i.seen, num_recs);
            chk_i.errors++;
        end
        total_errors = chk_i.errors + dut_i.props_i.fail_count;
        $display("errors: %0d, assertion failures: %0d, outputs checked: %0d",
                 total_errors, dut_i.props_i.fail_count, chk_i.seen);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/rv32_decode_pkg.sv
design/rf_read_if.sv
design/cl_decode.sv
design/imm_gen.sv
design/reg_file.sv
design/pipe_reg.sv
design/decode_stage.sv
verif/decode_checker.sv
verif/decode_stage_props.sv
verif/tb_decode_stage.sv
